// File: sources.f
+incdir+include
logic/videoPkg.sv
logic/gamePkg.sv
logic/sceneRegs.sv
logic/vgaTiming.sv
logic/spritePainter.sv
logic/videoOut.sv
logic/raceVideoTop.sv
verif/raceVideoChecker.sv
verif/raceVideoTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = raceVideoTb
FILELIST = sources.f
BUILD_DIR = obj_dir
SIM = $(BUILD_DIR)/V$(TOP)
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/raceVideoTb.sv
`timescale 1ns/1ps
`include "raceVideo_settings.svh"

module raceVideoTb import videoPkg::*, gamePkg::*; ();

	// Frame length and run limit in clocks
	localparam int frameCycles = `H_TOTAL * `V_TOTAL;
	localparam int timeoutCycles = 5 * frameCycles;
	// Clocks to wait for an ack before giving up
	localparam int ackLimit = 16;
	// Longest pause between two scene writes
	localparam int maxGap = 40000;

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	wbAddrType wbAdr;
	wbDataType wbDatW;
	wbDataType wbDatR;
	logic wbAck;
	syncType hSync;
	syncType vSync;
	rgbType rgb;

	// Counts from the checker
	int pixelErrors;
	int syncErrors;
	int busErrors;
	logic aligned;

	// Requests that never saw an ack
	int ackMisses;
	int cycleCount;

	raceVideoTop dut (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

	raceVideoChecker videoCheck (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb),
		.pixelErrors(pixelErrors),
		.syncErrors(syncErrors),
		.busErrors(busErrors),
		.aligned(aligned)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////////////////////////

	// One classic cycle, dropped as soon as ack shows
	task automatic busCycle(input logic we, input int adr, input int data);
		int waitCount;
		@(posedge clk);
		#1;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = wbAddrType'(adr);
		wbDatW = wbDataType'(data);
		waitCount = 0;
		do begin
			@(posedge clk);
			#1;
			waitCount++;
		end while (!wbAck && waitCount < ackLimit);
		if (!wbAck) begin
			$display("No Wishbone ack for address %0d after %0d clocks", adr, ackLimit);
			ackMisses++;
		end
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	// Random scene spread over the picture, then read back all words
	task automatic writeScene(input int scene);
		int value [8];
		// Enables walk 3, 2, 1, 0 so each bit is seen on and off
		value[0] = 3 - scene;
		value[1] = $urandom % `H_ACTIVE;
		value[2] = $urandom % `H_ACTIVE;
		value[3] = $urandom % `H_ACTIVE;
		// Scene 2 pushes obstacle 1 past the wrap line
		if (scene == 2) begin
			value[4] = `WRAP_Y + 1 + $urandom % (`V_ACTIVE - `WRAP_Y - 1);
		end else begin
			value[4] = $urandom % `V_ACTIVE;
		end
		value[5] = $urandom % `V_ACTIVE;
		value[6] = $urandom % `H_ACTIVE;
		// Unmapped word, must read back as zero
		value[7] = $urandom % 65536;
		for (int adr = 0; adr < 8; adr++) begin
			repeat ($urandom % maxGap) @(posedge clk);
			// junk in the top bits
			busCycle(1'b1, adr, (($urandom % 32) << 11) | value[adr]);
		end
		for (int adr = 0; adr < 8; adr++) begin
			busCycle(1'b0, adr, 0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int failures;
		void'($urandom(32'h6cef));
		ackMisses = 0;
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Scene 0 lands before the checker locks on
		repeat (4 * `H_TOTAL) @(posedge clk);
		writeScene(0);

		for (int frame = 1; frame < 4; frame++) begin
			@(negedge vSync);
			// Rest of blanking, then a few lines into the picture
			repeat ((`V_TOTAL - `V_ACTIVE - `V_FRONT + 4) * `H_TOTAL) @(posedge clk);
			writeScene(frame);
		end

		// Scene 3 goes active at this frame end and is drawn in the next
		@(negedge vSync);
		@(negedge vSync);
		repeat (4) @(posedge clk);

		failures = pixelErrors + syncErrors + busErrors + ackMisses;
		if (!aligned) begin
			$display("The checker never saw a vSync pulse to lock on to");
			failures++;
		end
		$display("Errors: pixel %0d, sync %0d, bus %0d, missing acks %0d",
			pixelErrors, syncErrors, busErrors, ackMisses);
		if (failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Hard stop a few dozen lines past the expected end
	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d clocks, the run did not finish", cycleCount);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: verif/raceVideoChecker.sv
`timescale 1ns/1ps
`include "raceVideo_settings.svh"

module raceVideoChecker import videoPkg::*, gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input wbAddrType wbAdr,
	input wbDataType wbDatW,
	input wbDataType wbDatR,
	input logic wbAck,
	input syncType hSync,
	input syncType vSync,
	input rgbType rgb,
	output int pixelErrors,
	output int syncErrors,
	output int busErrors,
	output logic aligned
);

	// Host register model, entry 7 stays zero
	int stage [8];
	// Staging one and two clocks back
	int hist1 [8];
	int hist2 [8];
	// Bank the picture is drawn from
	int act [8];

	// Model scan position of the pixel now on the pins
	int col;
	int row;
	logic vSyncPrev;

	// Request seen last clock
	logic expectAck;
	logic reqWe;
	int reqAdr;
	int reqDat;

	initial begin
		pixelErrors = 0;
		syncErrors = 0;
		busErrors = 0;
		aligned = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////////////////////////

	// Field width per word address
	function automatic int fieldMask(int adr);
		case (adr)
			0: return 32'h3;
			1, 2, 3, 6: return 32'h3ff;
			4, 5: return 32'h1ff;
			default: return 0;
		endcase
	endfunction

	// Strictly inside a car whose corner is (left, top)
	function automatic bit inCar(int x, int y, int left, int top);
		return (x > left) && (x < left + `CAR_W) && (y > top) && (y < top + `CAR_H);
	endfunction

	function automatic int modelColour(int x, int y);
		int colour;
		colour = colourBlack;
		if (x >= `H_ACTIVE || y >= `V_ACTIVE) begin
			return colourBlack;
		end
		if (act[0] & 1) begin
			// Roadside strips
			if (y > 0 && ((x > 0 && x < `BORDER_L_END) || x > `BORDER_R_START)) begin
				colour = colourGreen;
			end
			if (inCar(x, y, act[1], act[4]) || inCar(x, y, act[2], act[5])) begin
				colour = colourWhite;
			end
			// Wrapped part of obstacle 1, drawn at obstacle 3's column
			if (act[4] > `WRAP_Y && x > act[3] && x < act[3] + `CAR_W
				&& y > 0 && y < act[4] - `WRAP_Y) begin
				colour = colourWhite;
			end
		end
		if ((act[0] & 2) && inCar(x, y, act[6], `PLAYER_ROW)) begin
			colour = colourWhite;
		end
		return colour;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Per clock checks
	//////////////////////////////////////////////////////////////////////

	task automatic checkBus();
		if (wbAck !== expectAck) begin
			$display("FAILED at %0t: wbAck is %b, expected %b", $time, wbAck, expectAck);
			busErrors++;
		end
		if (wbAck && expectAck) begin
			if (reqWe) begin
				stage[reqAdr] = reqDat & fieldMask(reqAdr);
			end else if (wbDatR !== wbDataType'(stage[reqAdr])) begin
				$display("FAILED at %0t: read of address %0d gave %h, expected %h",
					$time, reqAdr, wbDatR, wbDataType'(stage[reqAdr]));
				busErrors++;
			end
		end
		// Ack due next clock
		expectAck = wbCyc && wbStb && !wbAck;
		reqWe = wbWe;
		reqAdr = int'(wbAdr);
		reqDat = int'(wbDatW);
	endtask

	task automatic checkVideo();
		logic expectH;
		logic expectV;
		int expectRgb;
		if (!aligned && vSyncPrev && !vSync) begin
			// First vSync fall is column 0 of line 490
			aligned = 1'b1;
			col = 0;
			row = `V_ACTIVE + `V_FRONT;
			// No writes happen in blanking so the first copy equals staging
			act = stage;
			hist1 = stage;
			hist2 = stage;
		end else if (aligned) begin
			if (col == `H_TOTAL - 1) begin
				col = 0;
				row = (row == `V_TOTAL - 1) ? 0 : row + 1;
			end else begin
				col++;
			end
		end
		vSyncPrev = vSync;
		if (aligned) begin
			hist2 = hist1;
			hist1 = stage;
			// Bank copy two clocks before this pixel reached the pins
			if (col == 0 && row == `V_ACTIVE) begin
				act = hist2;
			end
			expectH = !(col >= `H_ACTIVE + `H_FRONT && col < `H_ACTIVE + `H_FRONT + `H_SYNC);
			expectV = !(row >= `V_ACTIVE + `V_FRONT && row < `V_ACTIVE + `V_FRONT + `V_SYNC);
			if (hSync !== expectH || vSync !== expectV) begin
				$display("FAILED at %0t: syncs %b%b at (%0d,%0d), expected %b%b",
					$time, hSync, vSync, col, row, expectH, expectV);
				syncErrors++;
			end
			expectRgb = modelColour(col, row);
			if (rgb !== rgbType'(expectRgb)) begin
				$display("FAILED at %0t: rgb %0d at (%0d,%0d), expected %0d",
					$time, rgb, col, row, expectRgb);
				pixelErrors++;
			end
		end
	endtask

	// Pins settle after the rising edge, sample on the falling one
	always @(negedge clk) begin
		if (!rstN) begin
			if (hSync !== syncIdle || vSync !== syncIdle || rgb !== colourBlack
				|| wbAck !== 1'b0) begin
				$display("FAILED at %0t: outputs not at their reset levels", $time);
				syncErrors++;
			end
			stage = '{default: 0};
			hist1 = '{default: 0};
			hist2 = '{default: 0};
			act = '{default: 0};
			aligned = 1'b0;
			vSyncPrev = 1'b1;
			expectAck = 1'b0;
		end else begin
			// Video first so the history holds staging before this ack
			checkVideo();
			checkBus();
		end
	end

endmodule

// File: logic/raceVideoTop.sv
`timescale 1ns/1ps

module raceVideoTop import videoPkg::*, gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input wbAddrType wbAdr,
	input wbDataType wbDatW,
	output wbDataType wbDatR,
	output logic wbAck,
	output syncType hSync,
	output syncType vSync,
	output rgbType rgb
);

	// Scan position and raw timing
	pixelXType pixelX;
	pixelYType pixelY;
	syncType hSyncRaw;
	syncType vSyncRaw;
	logic visible;
	logic frameStart;

	// Active scene
	logic paintScene;
	logic paintPlayer;
	posXType obsX1;
	posXType obsX2;
	posXType obsX3;
	posYType obsY1;
	posYType obsY2;
	posXType playerX;

	// Painter output, one clock behind the counters
	rgbType colour;

	//////////////////////////////////////////////////////////////////////
	// Host registers
	//////////////////////////////////////////////////////////////////////

	sceneRegs uSceneRegs (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.frameStart(frameStart),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.paintScene(paintScene),
		.paintPlayer(paintPlayer),
		.obsX1(obsX1),
		.obsX2(obsX2),
		.obsX3(obsX3),
		.obsY1(obsY1),
		.obsY2(obsY2),
		.playerX(playerX)
	);

	//////////////////////////////////////////////////////////////////////
	// Video path
	//////////////////////////////////////////////////////////////////////

	vgaTiming uVgaTiming (
		.clk(clk),
		.rstN(rstN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.visible(visible),
		.frameStart(frameStart)
	);

	spritePainter uSpritePainter (
		.clk(clk),
		.rstN(rstN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.paintScene(paintScene),
		.paintPlayer(paintPlayer),
		.obsX1(obsX1),
		.obsX2(obsX2),
		.obsX3(obsX3),
		.obsY1(obsY1),
		.obsY2(obsY2),
		.playerX(playerX),
		.colour(colour)
	);

	// Pins two clocks after the counters
	videoOut uVideoOut (
		.clk(clk),
		.rstN(rstN),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.visible(visible),
		.colour(colour),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

endmodule

// File: logic/videoOut.sv
`timescale 1ns/1ps
`include "raceVideo_settings.svh"

module videoOut import videoPkg::*; (
	input logic clk,
	input logic rstN,
	input syncType hSyncRaw,
	input syncType vSyncRaw,
	input logic visible,
	input rgbType colour,
	output syncType hSync,
	output syncType vSync,
	output rgbType rgb
);

	// Match the painter register stages
	localparam int alignDepth = `PAINT_LATENCY;

	// Delay lines for timing beside the colour path
	syncType hSyncPipe [alignDepth];
	syncType vSyncPipe [alignDepth];
	logic visiblePipe [alignDepth];

	//////////////////////////////////////////////////////////////////////
	// Alignment
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < alignDepth; i++) begin
				hSyncPipe[i] <= syncIdle;
				vSyncPipe[i] <= syncIdle;
				visiblePipe[i] <= 1'b0;
			end
		end else begin
			hSyncPipe[0] <= hSyncRaw;
			vSyncPipe[0] <= vSyncRaw;
			visiblePipe[0] <= visible;
			// Remaining stages when the painter gets deeper
			for (int i = 1; i < alignDepth; i++) begin
				hSyncPipe[i] <= hSyncPipe[i - 1];
				vSyncPipe[i] <= vSyncPipe[i - 1];
				visiblePipe[i] <= visiblePipe[i - 1];
			end
		end
	end

	// Pin registers, black in blanking
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hSync <= syncIdle;
			vSync <= syncIdle;
			rgb <= colourBlack;
		end else begin
			hSync <= hSyncPipe[alignDepth - 1];
			vSync <= vSyncPipe[alignDepth - 1];
			rgb <= visiblePipe[alignDepth - 1] ? colour : colourBlack;
		end
	end

endmodule

// File: logic/spritePainter.sv
`timescale 1ns/1ps
`include "raceVideo_settings.svh"

module spritePainter import videoPkg::*, gamePkg::*; (
	input logic clk,
	input logic rstN,
	input pixelXType pixelX,
	input pixelYType pixelY,
	input logic paintScene,
	input logic paintPlayer,
	input posXType obsX1,
	input posXType obsX2,
	input posXType obsX3,
	input posYType obsY1,
	input posYType obsY2,
	input posXType playerX,
	output rgbType colour
);

	// Sizes and fixed screen features
	localparam pixelXType carW = pixelXType'(`CAR_W);
	localparam pixelYType carH = pixelYType'(`CAR_H);
	localparam pixelXType hActive = pixelXType'(`H_ACTIVE);
	localparam pixelYType vActive = pixelYType'(`V_ACTIVE);
	localparam pixelXType borderLEnd = pixelXType'(`BORDER_L_END);
	localparam pixelXType borderRStart = pixelXType'(`BORDER_R_START);
	localparam pixelYType playerTop = pixelYType'(`PLAYER_ROW);
	localparam pixelYType playerBottom = pixelYType'(`PLAYER_ROW + `CAR_H);
	localparam pixelYType wrapY = pixelYType'(`WRAP_Y);

	//////////////////////////////////////////////////////////////////////
	// Sprite edges
	//////////////////////////////////////////////////////////////////////

	// Right and bottom edges in counter width so the sums never wrap
	pixelXType obs1XEnd;
	pixelXType obs2XEnd;
	pixelXType obs3XEnd;
	pixelXType playerXEnd;
	pixelYType obs1YEnd;
	pixelYType obs2YEnd;
	pixelYType wrapYEnd;

	// Per layer hits
	logic inBorder;
	logic inObs1;
	logic inObs2;
	logic inWrap;
	logic inPlayer;

	// Colour for the current pixel
	rgbType nextColour;

	assign obs1XEnd = pixelXType'(obsX1) + carW;
	assign obs2XEnd = pixelXType'(obsX2) + carW;
	assign obs3XEnd = pixelXType'(obsX3) + carW;
	assign playerXEnd = pixelXType'(playerX) + carW;
	assign obs1YEnd = pixelYType'(obsY1) + carH;
	assign obs2YEnd = pixelYType'(obsY2) + carH;
	// Part of obstacle 1 that ran off the bottom
	assign wrapYEnd = pixelYType'(obsY1) - wrapY;

	//////////////////////////////////////////////////////////////////////
	// Hit tests, all strict
	//////////////////////////////////////////////////////////////////////

	// Left or right roadside strip
	assign inBorder = (pixelY > 0) && (pixelY < vActive)
		&& (((pixelX > 0) && (pixelX < borderLEnd))
		|| ((pixelX > borderRStart) && (pixelX < hActive)));

	assign inObs1 = (pixelX > obsX1) && (pixelX < obs1XEnd)
		&& (pixelY > obsY1) && (pixelY < obs1YEnd);

	assign inObs2 = (pixelX > obsX2) && (pixelX < obs2XEnd)
		&& (pixelY > obsY2) && (pixelY < obs2YEnd);

	// Third car only once obstacle 1 passes the wrap line
	assign inWrap = (obsY1 > wrapY)
		&& (pixelX > obsX3) && (pixelX < obs3XEnd)
		&& (pixelY > 0) && (pixelY < wrapYEnd);

	// Player car on its fixed row
	assign inPlayer = (pixelX > playerX) && (pixelX < playerXEnd)
		&& (pixelY > playerTop) && (pixelY < playerBottom);

	// Later layers win
	always_comb begin
		nextColour = colourBlack;
		if (paintScene) begin
			if (inBorder) begin
				nextColour = colourGreen;
			end
			if (inObs1 || inObs2 || inWrap) begin
				nextColour = colourWhite;
			end
		end
		if (paintPlayer && inPlayer) begin
			nextColour = colourWhite;
		end
	end

	// One clock of latency
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			colour <= colourBlack;
		end else begin
			colour <= nextColour;
		end
	end

endmodule

// File: logic/vgaTiming.sv
`timescale 1ns/1ps
`include "raceVideo_settings.svh"

module vgaTiming import videoPkg::*; (
	input logic clk,
	input logic rstN,
	output pixelXType pixelX,
	output pixelYType pixelY,
	output syncType hSyncRaw,
	output syncType vSyncRaw,
	output logic visible,
	output logic frameStart
);

	// Horizontal points in columns
	localparam pixelXType hActive = pixelXType'(`H_ACTIVE);
	localparam pixelXType hSyncStart = pixelXType'(`H_ACTIVE + `H_FRONT);
	localparam pixelXType hSyncEnd = pixelXType'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam pixelXType hTotal = pixelXType'(`H_TOTAL);

	// Vertical points in lines
	localparam pixelYType vActive = pixelYType'(`V_ACTIVE);
	localparam pixelYType vSyncStart = pixelYType'(`V_ACTIVE + `V_FRONT);
	localparam pixelYType vSyncEnd = pixelYType'(`V_ACTIVE + `V_FRONT + `V_SYNC);
	localparam pixelYType vTotal = pixelYType'(`V_TOTAL);

	// Last column of a line and last line of a frame
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (pixelX == hTotal - 1'b1);
	assign frameEnd = (pixelY == vTotal - 1'b1);

	//////////////////////////////////////////////////////////////////////
	// Scan counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pixelX <= '0;
			pixelY <= '0;
		end else if (lineEnd) begin
			pixelX <= '0;
			// Next line or back to the top
			if (frameEnd) begin
				pixelY <= '0;
			end else begin
				pixelY <= pixelY + 1'b1;
			end
		end else begin
			pixelX <= pixelX + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decoded windows
	//////////////////////////////////////////////////////////////////////

	// Sync pulses inside the blanking intervals
	assign hSyncRaw = (pixelX >= hSyncStart && pixelX < hSyncEnd) ? syncActive : syncIdle;
	assign vSyncRaw = (pixelY >= vSyncStart && pixelY < vSyncEnd) ? syncActive : syncIdle;

	// 640x480 drawn area
	assign visible = (pixelX < hActive) && (pixelY < vActive);

	// First pixel after the last visible line
	assign frameStart = (pixelX == '0) && (pixelY == vActive);

	// Counters never leave the frame
	counterRange: assert property (@(posedge clk) disable iff (!rstN)
		(pixelX < hTotal) && (pixelY < vTotal));

endmodule

// File: logic/sceneRegs.sv
`timescale 1ns/1ps

module sceneRegs import gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input wbAddrType wbAdr,
	input wbDataType wbDatW,
	input logic frameStart,
	output wbDataType wbDatR,
	output logic wbAck,
	output logic paintScene,
	output logic paintPlayer,
	output posXType obsX1,
	output posXType obsX2,
	output posXType obsX3,
	output posYType obsY1,
	output posYType obsY2,
	output posXType playerX
);

	// New request, not yet acked
	logic wbReq;

	// Staging bank seen by the host
	ctrlType stageCtrl;
	posXType stageObsX1;
	posXType stageObsX2;
	posXType stageObsX3;
	posYType stageObsY1;
	posYType stageObsY2;
	posXType stagePlayerX;

	// Active bank seen by the painter
	ctrlType activeCtrl;

	// Staging word at wbAdr
	wbDataType readMux;

	assign wbReq = wbCyc && wbStb && !wbAck;

	assign paintScene = activeCtrl[ctrlSceneBit];
	assign paintPlayer = activeCtrl[ctrlPlayerBit];

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	// Zero extended fields, zero above the map
	always_comb begin
		readMux = '0;
		case (regAddrType'(wbAdr))
			addrControl: readMux = wbDataType'(stageCtrl);
			addrObsX1: readMux = wbDataType'(stageObsX1);
			addrObsX2: readMux = wbDataType'(stageObsX2);
			addrObsX3: readMux = wbDataType'(stageObsX3);
			addrObsY1: readMux = wbDataType'(stageObsY1);
			addrObsY2: readMux = wbDataType'(stageObsY2);
			addrPlayerX: readMux = wbDataType'(stagePlayerX);
			default: readMux = '0;
		endcase
	end

	// Single cycle ack, read data held with it
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			wbDatR <= '0;
		end else begin
			wbAck <= wbReq;
			if (wbReq && !wbWe) begin
				wbDatR <= readMux;
			end
		end
	end

	// Writes land on the ack edge
	// high bits beyond each field are dropped
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stageCtrl <= '0;
			stageObsX1 <= '0;
			stageObsX2 <= '0;
			stageObsX3 <= '0;
			stageObsY1 <= '0;
			stageObsY2 <= '0;
			stagePlayerX <= '0;
		end else if (wbReq && wbWe) begin
			case (regAddrType'(wbAdr))
				addrControl: stageCtrl <= wbDatW[$bits(ctrlType)-1:0];
				addrObsX1: stageObsX1 <= wbDatW[$bits(posXType)-1:0];
				addrObsX2: stageObsX2 <= wbDatW[$bits(posXType)-1:0];
				addrObsX3: stageObsX3 <= wbDatW[$bits(posXType)-1:0];
				addrObsY1: stageObsY1 <= wbDatW[$bits(posYType)-1:0];
				addrObsY2: stageObsY2 <= wbDatW[$bits(posYType)-1:0];
				addrPlayerX: stagePlayerX <= wbDatW[$bits(posXType)-1:0];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame boundary copy
	//////////////////////////////////////////////////////////////////////

	// Whole bank at once so a frame never mixes old and new values
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			activeCtrl <= '0;
			obsX1 <= '0;
			obsX2 <= '0;
			obsX3 <= '0;
			obsY1 <= '0;
			obsY2 <= '0;
			playerX <= '0;
		end else if (frameStart) begin
			activeCtrl <= stageCtrl;
			obsX1 <= stageObsX1;
			obsX2 <= stageObsX2;
			obsX3 <= stageObsX3;
			obsY1 <= stageObsY1;
			obsY2 <= stageObsY2;
			playerX <= stagePlayerX;
		end
	end

	// Ack is a single pulse
	ackOnePulse: assert property (@(posedge clk) disable iff (!rstN)
		wbAck |=> !wbAck);

	// No ack without a request the cycle before
	ackAfterReq: assert property (@(posedge clk) disable iff (!rstN)
		wbAck |-> $past(wbCyc && wbStb));

endmodule

// File: logic/gamePkg.sv
package gamePkg;

	// Object positions as written by the host
	typedef logic [9:0] posXType;
	typedef logic [8:0] posYType;

	// Wishbone word and word address
	typedef logic [15:0] wbDataType;
	typedef logic [2:0] wbAddrType;

	// Register map, one word per entry
	typedef enum logic [2:0] {
		addrControl = 3'd0,
		addrObsX1 = 3'd1,
		addrObsX2 = 3'd2,
		addrObsX3 = 3'd3,
		addrObsY1 = 3'd4,
		addrObsY2 = 3'd5,
		addrPlayerX = 3'd6
	} regAddrType;

	// Control word bits
	typedef logic [1:0] ctrlType;
	localparam int ctrlSceneBit = 0;
	localparam int ctrlPlayerBit = 1;

endpackage

// File: logic/videoPkg.sv
package videoPkg;

	//////////////////////////////////////////////////////////////////////
	// Screen coordinates
	//////////////////////////////////////////////////////////////////////

	// Column counter, wide enough for the 800 column total
	typedef logic [10:0] pixelXType;
	// Line counter for the 525 line total
	typedef logic [9:0] pixelYType;

	// One bit per colour gun
	typedef logic [2:0] rgbType;

	// Named colours
	localparam rgbType colourBlack = 3'd0;
	localparam rgbType colourGreen = 3'd3;
	localparam rgbType colourWhite = 3'd7;

	//////////////////////////////////////////////////////////////////////
	// Sync levels
	//////////////////////////////////////////////////////////////////////

	// Both VGA syncs are active low
	typedef logic syncType;
	localparam syncType syncActive = 1'b0;
	localparam syncType syncIdle = 1'b1;

endpackage

// File: include/raceVideo_settings.svh
`ifndef RACEVIDEO_SETTINGS_SVH
`define RACEVIDEO_SETTINGS_SVH

// Horizontal timing in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Car sprite size
`define CAR_W 65
`define CAR_H 70

// Road edges
`define BORDER_L_END 215
`define BORDER_R_START 405

// Top line of the player car
`define PLAYER_ROW 390

// Obstacle 1 past this line shows again at the top
`define WRAP_Y 410

// Register stages in the painter
`define PAINT_LATENCY 1

`endif
